/* hdl/armCtrlPkg.sv */
package armCtrlPkg;

  // Word and field widths
  typedef logic [31:0] instrT;
  typedef logic [3:0]  flagsT;    // N Z C V, N in bit 3
  typedef logic [3:0]  condT;
  typedef logic [3:0]  aluCtrlT;
  typedef logic [2:0]  multCtrlT;
  typedef logic [1:0]  fwdT;

  // Forwarding selects for the ALU source muxes
  localparam fwdT FwdNone = 2'b00;
  localparam fwdT FwdW    = 2'b01;   // Result from Writeback
  localparam fwdT FwdM    = 2'b10;   // ALU result from Memory

  // Instruction classes seen by the decoder
  typedef enum logic [2:0] {
    DpImm,
    DpReg,
    Mult,
    Ldr,
    Str,
    Branch,
    Undef
  } opClassT;

  // Condition field encodings
  localparam condT CondEq = 4'b0000;
  localparam condT CondNe = 4'b0001;
  localparam condT CondCs = 4'b0010;
  localparam condT CondCc = 4'b0011;
  localparam condT CondMi = 4'b0100;
  localparam condT CondPl = 4'b0101;
  localparam condT CondVs = 4'b0110;
  localparam condT CondVc = 4'b0111;
  localparam condT CondHi = 4'b1000;
  localparam condT CondLs = 4'b1001;
  localparam condT CondGe = 4'b1010;
  localparam condT CondLt = 4'b1011;
  localparam condT CondGt = 4'b1100;
  localparam condT CondLe = 4'b1101;
  localparam condT CondAl = 4'b1110;

  // ALU add, used for address and branch target arithmetic
  localparam aluCtrlT AluAdd = 4'b0100;

  // Bits 7:4 of a multiply in the register data-processing space
  localparam logic [3:0] MultSig = 4'b1001;

  // Program counter register number
  localparam logic [3:0] PcReg = 4'd15;

endpackage

/* hdl/mainDecoder.sv */
module mainDecoder (
  input  armCtrlPkg::instrT    InstrD,
  output logic [1:0]           RegSrcD,
  output logic [1:0]           ImmSrcD,
  output logic                 ALUSrcD,
  output logic                 MemtoRegD,
  output logic                 RegWriteD,
  output logic                 MemWriteD,
  output logic                 BranchD,
  output logic                 multSelectD,
  output armCtrlPkg::aluCtrlT  ALUControlD,
  output logic [1:0]           FlagWriteD,
  output armCtrlPkg::multCtrlT MultControlD,
  output logic                 PCSrcD,
  output armCtrlPkg::opClassT  opClass
);
  import armCtrlPkg::*;

  logic [8:0] controls;
  logic       dpOp;

  // Instruction class from the op field and the multiply signature
  always_comb begin
    case (InstrD[27:25])
      3'b000:  opClass = (InstrD[7:4] == MultSig) ? Mult : DpReg;
      3'b001:  opClass = DpImm;
      3'b010,
      3'b011:  opClass = InstrD[20] ? Ldr : Str;   // L bit picks load or store
      3'b101:  opClass = Branch;
      default: opClass = Undef;
    endcase
  end

  // RegSrc ImmSrc ALUSrc MemtoReg RegWrite MemWrite Branch
  always_comb begin
    case (opClass)
      DpImm:   controls = 9'b00_00_10100;
      DpReg:   controls = 9'b00_00_00100;
      Mult:    controls = 9'b00_00_00100;
      Ldr:     controls = 9'b00_01_11100;
      Str:     controls = 9'b10_01_10010;
      Branch:  controls = 9'b01_10_10001;
      default: controls = 9'b00_00_00000;   // Undefined does nothing
    endcase
  end

  assign {RegSrcD, ImmSrcD, ALUSrcD, MemtoRegD,
          RegWriteD, MemWriteD, BranchD} = controls;

  assign dpOp        = (opClass == DpImm) || (opClass == DpReg);
  assign multSelectD = (opClass == Mult);

  always_comb begin
    if (dpOp) begin
      ALUControlD = InstrD[24:21];              // Opcode goes straight to the ALU
      FlagWriteD  = {InstrD[20], InstrD[20]};   // S bit sets both groups
    end else begin
      ALUControlD = AluAdd;
      FlagWriteD  = 2'b00;
    end
  end

  // MUL, MLA, UMULL and friends
  assign MultControlD = InstrD[23:21];

  // Branches and writes to r15 both redirect the fetch
  assign PCSrcD = BranchD || (RegWriteD && (InstrD[15:12] == PcReg));

endmodule

/* hdl/conditional.sv */
module conditional (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  armCtrlPkg::condT    CondE,
  input  armCtrlPkg::flagsT   FlagsE,
  input  logic [1:0]          FlagWriteE,
  output logic                CondExE,
  output armCtrlPkg::flagsT   storedFlags
);
  import armCtrlPkg::*;

  logic       neg;
  logic       zero;
  logic       carry;
  logic       oflow;
  logic       ge;
  logic [1:0] flagWrEn;

  assign {neg, zero, carry, oflow} = storedFlags;
  assign ge = (neg == oflow);   // Signed greater or equal

  always_comb begin
    case (CondE)
      CondEq:  CondExE = zero;
      CondNe:  CondExE = !zero;
      CondCs:  CondExE = carry;
      CondCc:  CondExE = !carry;
      CondMi:  CondExE = neg;
      CondPl:  CondExE = !neg;
      CondVs:  CondExE = oflow;
      CondVc:  CondExE = !oflow;
      CondHi:  CondExE = carry && !zero;
      CondLs:  CondExE = !carry || zero;
      CondGe:  CondExE = ge;
      CondLt:  CondExE = !ge;
      CondGt:  CondExE = !zero && ge;
      CondLe:  CondExE = zero || !ge;
      CondAl:  CondExE = 1'b1;
      default: CondExE = 1'b0;   // 1111 never executes here
    endcase
  end

  // Only an instruction that passed its condition may touch the flags
  assign flagWrEn = FlagWriteE & {2{CondExE}};

  always_ff @(posedge clk) begin
    if (rst) begin
      storedFlags <= '0;
    end else if (en) begin
      if (flagWrEn[1]) begin
        storedFlags[3:2] <= FlagsE[3:2];   // N and Z
      end
      if (flagWrEn[0]) begin
        storedFlags[1:0] <= FlagsE[1:0];   // C and V
      end
    end
  end

  flagsClearAfterReset: assert property (@(posedge clk) rst |=> storedFlags == '0)
    else $error("Stored flags not cleared by reset");

endmodule

/* hdl/hazard.sv */
module hazard (
  input  logic            Match1EM,
  input  logic            Match1EW,
  input  logic            Match2EM,
  input  logic            Match2EW,
  input  logic            Match12DE,
  input  logic            RegWriteM,
  input  logic            RegWriteW,
  input  logic            MemtoRegE,
  input  logic            PCWrPendingF,
  input  logic            PCSrcW,
  input  logic            BranchTakenE,
  input  logic            memWait,
  output armCtrlPkg::fwdT ForwardAE,
  output armCtrlPkg::fwdT ForwardBE,
  output logic            StallF,
  output logic            StallD,
  output logic            StallE,
  output logic            StallM,
  output logic            FlushD,
  output logic            FlushE,
  output logic            FlushW
);
  import armCtrlPkg::*;

  logic ldrStall;

  // Newest producer wins
  function automatic fwdT fwdSel(input logic matchM, input logic matchW,
                                 input logic wrM, input logic wrW);
    fwdT sel;
    if (matchM && wrM) begin
      sel = FwdM;
    end else if (matchW && wrW) begin
      sel = FwdW;
    end else begin
      sel = FwdNone;
    end
    return sel;
  endfunction

  assign ForwardAE = fwdSel(Match1EM, Match1EW, RegWriteM, RegWriteW);
  assign ForwardBE = fwdSel(Match2EM, Match2EW, RegWriteM, RegWriteW);

  // Load in E feeding the instruction in D
  assign ldrStall = MemtoRegE && Match12DE;

  assign StallF = ldrStall || PCWrPendingF || memWait;
  assign StallD = ldrStall || memWait;
  assign StallE = memWait;
  assign StallM = memWait;

  assign FlushD = PCSrcW || BranchTakenE;
  assign FlushE = (ldrStall || BranchTakenE) && !memWait;   // Held stage keeps its contents
  assign FlushW = memWait;                                 // Bubble into Writeback

endmodule

/* hdl/controller.sv */
module controller (
  input  logic                 clk,
  input  logic                 rst,
  input  armCtrlPkg::instrT    InstrD,
  input  armCtrlPkg::flagsT    FlagsE,
  input  logic                 StallE,
  input  logic                 StallM,
  input  logic                 FlushE,
  input  logic                 FlushW,
  output logic [1:0]           RegSrcD,
  output logic [1:0]           ImmSrcD,
  output logic                 ALUSrcE,
  output armCtrlPkg::aluCtrlT  ALUControlE,
  output armCtrlPkg::multCtrlT MultControlE,
  output logic                 BranchTakenE,
  output logic                 MemtoRegE,
  output logic                 MemWriteM,
  output logic                 MemtoRegM,
  output logic                 RegWriteM,
  output logic                 MemtoRegW,
  output logic                 RegWriteW,
  output logic                 PCSrcW,
  output logic                 PCWrPendingF,
  output logic [1:0]           previousCVflag
);
  import armCtrlPkg::*;

  logic       ALUSrcD, MemtoRegD, RegWriteD, MemWriteD, BranchD, multSelectD, PCSrcD;
  aluCtrlT    ALUControlD;
  multCtrlT   MultControlD;
  logic [1:0] FlagWriteD;
  opClassT    opClassD;

  logic       RegWriteE, MemWriteE, BranchE, PCSrcE;
  logic [1:0] FlagWriteE;
  opClassT    opClassE;
  condT       CondE;
  logic       CondExE;
  flagsT      storedFlags;

  logic       RegWriteGatedE, MemWriteGatedE, PCSrcGatedE;
  logic       PCSrcM;

  mainDecoder i_mainDecoder (
    .InstrD       (InstrD),
    .RegSrcD      (RegSrcD),
    .ImmSrcD      (ImmSrcD),
    .ALUSrcD      (ALUSrcD),
    .MemtoRegD    (MemtoRegD),
    .RegWriteD    (RegWriteD),
    .MemWriteD    (MemWriteD),
    .BranchD      (BranchD),
    .multSelectD  (multSelectD),
    .ALUControlD  (ALUControlD),
    .FlagWriteD   (FlagWriteD),
    .MultControlD (MultControlD),
    .PCSrcD       (PCSrcD),
    .opClass      (opClassD)
  );

  // Execute stage control bits, a flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (rst || FlushE) begin
      RegWriteE  <= 1'b0;
      MemWriteE  <= 1'b0;
      MemtoRegE  <= 1'b0;
      BranchE    <= 1'b0;
      PCSrcE     <= 1'b0;
      FlagWriteE <= 2'b00;
      opClassE   <= Undef;
    end else if (!StallE) begin
      RegWriteE  <= RegWriteD;
      MemWriteE  <= MemWriteD;
      MemtoRegE  <= MemtoRegD;
      BranchE    <= BranchD;
      PCSrcE     <= PCSrcD;
      FlagWriteE <= FlagWriteD;
      opClassE   <= opClassD;
    end
  end

  // Operand controls, harmless in a bubble
  always_ff @(posedge clk) begin
    if (!StallE) begin
      CondE        <= InstrD[31:28];
      ALUSrcE      <= ALUSrcD;
      ALUControlE  <= ALUControlD;
      MultControlE <= multSelectD ? MultControlD : '0;   // Multiplier idle otherwise
    end
  end

  // Flags advance only when the Execute instruction moves on
  conditional i_conditional (
    .clk         (clk),
    .rst         (rst),
    .en          (!StallE),
    .CondE       (CondE),
    .FlagsE      (FlagsE),
    .FlagWriteE  (FlagWriteE),
    .CondExE     (CondExE),
    .storedFlags (storedFlags)
  );

  assign BranchTakenE   = BranchE && CondExE;
  assign RegWriteGatedE = RegWriteE && CondExE;
  assign MemWriteGatedE = MemWriteE && CondExE;
  assign PCSrcGatedE    = PCSrcE && CondExE;

  assign previousCVflag = storedFlags[1:0];   // Carry-in for ADC, SBC, RSC

  always_ff @(posedge clk) begin
    if (rst) begin
      MemWriteM <= 1'b0;
      MemtoRegM <= 1'b0;
      RegWriteM <= 1'b0;
      PCSrcM    <= 1'b0;
    end else if (!StallM) begin
      MemWriteM <= MemWriteGatedE;
      MemtoRegM <= MemtoRegE;
      RegWriteM <= RegWriteGatedE;
      PCSrcM    <= PCSrcGatedE;
    end
  end

  // Writeback takes a bubble while memory waits
  always_ff @(posedge clk) begin
    if (rst || FlushW) begin
      MemtoRegW <= 1'b0;
      RegWriteW <= 1'b0;
      PCSrcW    <= 1'b0;
    end else begin
      MemtoRegW <= MemtoRegM;
      RegWriteW <= RegWriteM;
      PCSrcW    <= PCSrcM;
    end
  end

  // E is not gated by the condition, the fetch waits either way
  assign PCWrPendingF = PCSrcD || PCSrcE || PCSrcM;

  branchFromDecodedB: assert property (@(posedge clk) disable iff (rst)
    BranchTakenE |-> BranchE && (opClassE == Branch))
    else $error("Branch taken for a non-branch in Execute");

  noLoadAndStoreM: assert property (@(posedge clk) disable iff (rst)
    !(MemWriteM && MemtoRegM))
    else $error("Load and store together in Memory");

endmodule

/* hdl/armControlUnit.sv */
module armControlUnit (
  input  logic                 clk,
  input  logic                 rst,
  input  armCtrlPkg::instrT    InstrD,
  input  armCtrlPkg::flagsT    FlagsE,
  input  logic                 Match1EM,
  input  logic                 Match1EW,
  input  logic                 Match2EM,
  input  logic                 Match2EW,
  input  logic                 Match12DE,
  input  logic                 memWait,
  output logic [1:0]           RegSrcD,
  output logic [1:0]           ImmSrcD,
  output logic                 ALUSrcE,
  output armCtrlPkg::aluCtrlT  ALUControlE,
  output armCtrlPkg::multCtrlT MultControlE,
  output logic                 BranchTakenE,
  output logic                 MemtoRegE,
  output logic                 MemWriteM,
  output logic                 MemtoRegM,
  output logic                 RegWriteM,
  output logic                 MemtoRegW,
  output logic                 RegWriteW,
  output logic                 PCSrcW,
  output logic                 PCWrPendingF,
  output logic [1:0]           previousCVflag,
  output logic                 StallF,
  output logic                 StallD,
  output logic                 FlushD,
  output armCtrlPkg::fwdT      ForwardAE,
  output armCtrlPkg::fwdT      ForwardBE
);

  logic StallE, StallM, FlushE, FlushW;

  controller i_controller (
    .clk            (clk),
    .rst            (rst),
    .InstrD         (InstrD),
    .FlagsE         (FlagsE),
    .StallE         (StallE),
    .StallM         (StallM),
    .FlushE         (FlushE),
    .FlushW         (FlushW),
    .RegSrcD        (RegSrcD),
    .ImmSrcD        (ImmSrcD),
    .ALUSrcE        (ALUSrcE),
    .ALUControlE    (ALUControlE),
    .MultControlE   (MultControlE),
    .BranchTakenE   (BranchTakenE),
    .MemtoRegE      (MemtoRegE),
    .MemWriteM      (MemWriteM),
    .MemtoRegM      (MemtoRegM),
    .RegWriteM      (RegWriteM),
    .MemtoRegW      (MemtoRegW),
    .RegWriteW      (RegWriteW),
    .PCSrcW         (PCSrcW),
    .PCWrPendingF   (PCWrPendingF),
    .previousCVflag (previousCVflag)
  );

  hazard i_hazard (
    .Match1EM     (Match1EM),
    .Match1EW     (Match1EW),
    .Match2EM     (Match2EM),
    .Match2EW     (Match2EW),
    .Match12DE    (Match12DE),
    .RegWriteM    (RegWriteM),
    .RegWriteW    (RegWriteW),
    .MemtoRegE    (MemtoRegE),
    .PCWrPendingF (PCWrPendingF),
    .PCSrcW       (PCSrcW),
    .BranchTakenE (BranchTakenE),
    .memWait      (memWait),
    .ForwardAE    (ForwardAE),
    .ForwardBE    (ForwardBE),
    .StallF       (StallF),
    .StallD       (StallD),
    .StallE       (StallE),
    .StallM       (StallM),
    .FlushD       (FlushD),
    .FlushE       (FlushE),
    .FlushW       (FlushW)
  );

  // The E registers in the controller rely on these never meeting
  noStallAndFlushE: assert property (@(posedge clk) disable iff (rst)
    !(StallE && FlushE))
    else $error("Execute stalled and flushed in the same cycle");

endmodule

/* bench/tbControlUnit.sv */
module tbControlUnit;
  timeunit 1ns;
  timeprecision 100ps;
  import armCtrlPkg::*;

  localparam int NumCycles     = 1000;
  localparam int TimeoutCycles = 2 * NumCycles;   // Twice the stimulus length

  logic       clk = 1'b0;
  logic       rst;
  instrT      InstrD;
  flagsT      FlagsE;
  logic       Match1EM, Match1EW, Match2EM, Match2EW, Match12DE, memWait;
  logic [1:0] RegSrcD, ImmSrcD, previousCVflag;
  logic       ALUSrcE, BranchTakenE, MemtoRegE, MemWriteM, MemtoRegM, RegWriteM;
  logic       MemtoRegW, RegWriteW, PCSrcW, PCWrPendingF, StallF, StallD, FlushD;
  aluCtrlT    ALUControlE;
  multCtrlT   MultControlE;
  fwdT        ForwardAE, ForwardBE;

  logic [31:0] seed;
  int          mismatches = 0;
  int          cycles = 0;

  // Reference model of the E slot, the M and W control bits and the flags
  logic    eValid, mRegWrite, mMemWrite, mMemtoReg, wRegWrite, wMemtoReg;
  logic    mPCSrc, wPCSrc;
  instrT   eInstr;
  flagsT   modelFlags;
  opClassT eClass, dClass;
  logic    ePass, expBranch, expMemtoRegE, expLdStall, expFlushE, ePCSrc, expPending;

  armControlUnit i_armControlUnit (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Instruction class from the ARM op field and the multiply signature
  function automatic opClassT classify(input instrT w);
    opClassT c;
    if (w[27:25] == 3'b001) begin
      c = DpImm;
    end else if (w[27:25] == 3'b000) begin
      c = (w[7:4] == 4'b1001) ? Mult : DpReg;
    end else if (w[27:26] == 2'b01) begin
      c = w[20] ? Ldr : Str;
    end else if (w[27:25] == 3'b101) begin
      c = Branch;
    end else begin
      c = Undef;
    end
    return c;
  endfunction

  // Branch, or a register write whose Rd field names r15
  function automatic logic writesPc(input instrT w);
    opClassT c;
    c = classify(w);
    return (c == Branch) || ((c inside {DpImm, DpReg, Mult, Ldr}) && (w[15:12] == PcReg));
  endfunction

  // Odd condition codes invert the base test of the even code below them
  function automatic logic condPass(input condT c, input flagsT f);
    logic n, z, cy, v, base;
    {n, z, cy, v} = f;
    case (c[3:1])
      3'b000:  base = z;
      3'b001:  base = cy;
      3'b010:  base = n;
      3'b011:  base = v;
      3'b100:  base = cy && !z;
      3'b101:  base = (n == v);
      3'b110:  base = !z && (n == v);
      default: base = !c[0];   // Only AL passes
    endcase
    return (c[3:1] == 3'b111) ? base : (base ^ c[0]);
  endfunction

  function automatic instrT randInstr();
    instrT       w;
    logic [31:0] r;
    w = nextRand();
    r = nextRand();
    case (r[31:29])
      3'd0: w[27:25] = 3'b000;
      3'd1: begin
        w[27:25] = 3'b000;
        w[7:4]   = 4'b1001;   // Multiply
      end
      3'd2: w[27:25] = 3'b001;
      3'd3: w[27:20] = {3'b010, w[24:21], 1'b1};   // Load
      3'd4: w[27:20] = {3'b010, w[24:21], 1'b0};   // Store
      3'd5,
      3'd6: w[27:25] = 3'b101;
      default: ;
    endcase
    if (r[28]) begin
      w[31:28] = CondAl;
    end
    return w;
  endfunction

  task automatic driveRandom();
    logic [31:0] r;
    r = nextRand();
    InstrD  = randInstr();
    FlagsE  = r[31:28];
    {Match1EM, Match1EW, Match2EM, Match2EW, Match12DE} = r[27:23];
    memWait = (r[22:20] == 3'b000);   // Slow memory about one cycle in eight
  endtask

  task automatic reportMismatch(input string what);
    mismatches++;
    $display("Mismatch at %0d ns: %s", $time, what);
  endtask

  assign eClass       = classify(eInstr);
  assign dClass       = classify(InstrD);
  assign ePass        = eValid && condPass(eInstr[31:28], modelFlags);
  assign expBranch    = ePass && (eClass == Branch);
  assign expMemtoRegE = eValid && (eClass == Ldr);
  assign expLdStall   = expMemtoRegE && Match12DE;
  assign expFlushE    = !memWait && (expBranch || expLdStall);
  assign ePCSrc       = eValid && writesPc(eInstr);
  assign expPending   = writesPc(InstrD) || ePCSrc || mPCSrc;

  always @(posedge clk) begin
    if (rst) begin
      eValid     <= 1'b0;
      eInstr     <= '0;
      mRegWrite  <= 1'b0;
      mMemWrite  <= 1'b0;
      mMemtoReg  <= 1'b0;
      mPCSrc     <= 1'b0;
      wRegWrite  <= 1'b0;
      wMemtoReg  <= 1'b0;
      wPCSrc     <= 1'b0;
      modelFlags <= '0;
    end else begin
      if (!memWait) begin
        eValid    <= !expFlushE;
        eInstr    <= InstrD;
        mRegWrite <= ePass && (eClass inside {DpImm, DpReg, Mult, Ldr});
        mMemWrite <= ePass && (eClass == Str);
        mMemtoReg <= expMemtoRegE;
        mPCSrc    <= ePass && writesPc(eInstr);
        if (ePass && (eClass inside {DpImm, DpReg}) && eInstr[20]) begin
          modelFlags <= FlagsE;   // S bit, condition passed
        end
      end
      wRegWrite <= mRegWrite && !memWait;
      wMemtoReg <= mMemtoReg && !memWait;
      wPCSrc    <= mPCSrc && !memWait;
    end
  end

  resetClears: assert property (@(posedge clk) rst |=> !RegWriteW && !MemtoRegW && !PCSrcW
      && !MemWriteM && !RegWriteM && !BranchTakenE && !PCWrPendingF)
    else reportMismatch("control outputs not low after reset");
  branchCond: assert property (@(posedge clk) disable iff (rst) BranchTakenE == expBranch)
    else reportMismatch("BranchTakenE disagrees with the condition table");
  storedCV: assert property (@(posedge clk) disable iff (rst)
      previousCVflag == modelFlags[1:0])
    else reportMismatch("stored C and V flags wrong");
  decodeSel: assert property (@(posedge clk) disable iff (rst)
      RegSrcD == {dClass == Str, dClass == Branch}
      && ImmSrcD == ((dClass == Branch) ? 2'b10 : (dClass inside {Ldr, Str}) ? 2'b01 : 2'b00))
    else reportMismatch("RegSrcD or ImmSrcD wrong");
  aluCodeE: assert property (@(posedge clk) disable iff (rst)
      eValid && (eClass inside {DpImm, DpReg}) |-> ALUControlE == eInstr[24:21])
    else reportMismatch("ALUControlE is not the opcode of the E instruction");
  operandE: assert property (@(posedge clk) disable iff (rst)
      ALUSrcE == (eClass inside {DpImm, Ldr, Str, Branch})
      && (eClass != Mult || MultControlE == eInstr[23:21]))
    else reportMismatch("ALUSrcE or MultControlE wrong");
  loadInE: assert property (@(posedge clk) disable iff (rst) MemtoRegE == expMemtoRegE)
    else reportMismatch("MemtoRegE wrong");
  memStage: assert property (@(posedge clk) disable iff (rst)
      RegWriteM == mRegWrite && MemWriteM == mMemWrite && MemtoRegM == mMemtoReg)
    else reportMismatch("M stage controls wrong");
  wbStage: assert property (@(posedge clk) disable iff (rst)
      RegWriteW == wRegWrite && MemtoRegW == wMemtoReg)
    else reportMismatch("W stage controls wrong");
  pcWriteW: assert property (@(posedge clk) disable iff (rst) PCSrcW == wPCSrc)
    else reportMismatch("PCSrcW wrong");
  pcPending: assert property (@(posedge clk) disable iff (rst) PCWrPendingF == expPending)
    else reportMismatch("PCWrPendingF wrong");
  loadUse: assert property (@(posedge clk) disable iff (rst)
      MemtoRegE && Match12DE && !memWait |-> StallF && StallD && i_armControlUnit.FlushE)
    else reportMismatch("load-use hazard not stalled");
  stallFD: assert property (@(posedge clk) disable iff (rst)
      StallF == (expLdStall || expPending || memWait) && StallD == (expLdStall || memWait))
    else reportMismatch("StallF or StallD wrong");
  flushDec: assert property (@(posedge clk) disable iff (rst) FlushD == (wPCSrc || expBranch))
    else reportMismatch("FlushD wrong");
  flushExec: assert property (@(posedge clk) disable iff (rst)
      i_armControlUnit.FlushE == expFlushE)
    else reportMismatch("FlushE wrong");
  fwdA: assert property (@(posedge clk) disable iff (rst) ForwardAE ==
      ((Match1EM && RegWriteM) ? FwdM : (Match1EW && RegWriteW) ? FwdW : FwdNone))
    else reportMismatch("ForwardAE priority wrong");
  fwdB: assert property (@(posedge clk) disable iff (rst) ForwardBE ==
      ((Match2EM && RegWriteM) ? FwdM : (Match2EW && RegWriteW) ? FwdW : FwdNone))
    else reportMismatch("ForwardBE priority wrong");
  waitHoldsM: assert property (@(posedge clk) disable iff (rst) memWait |=>
      $stable(RegWriteM) && $stable(MemWriteM) && $stable(MemtoRegM))
    else reportMismatch("M outputs moved during memory wait");
  waitBubbleW: assert property (@(posedge clk) disable iff (rst)
      memWait |=> !RegWriteW && !MemtoRegW && !PCSrcW)
    else reportMismatch("W outputs not cleared after memory wait");
  waitNoFlush: assert property (@(posedge clk) disable iff (rst)
      memWait |-> !i_armControlUnit.FlushE)
    else reportMismatch("FlushE high during memory wait");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout: run did not end within %0d cycles", TimeoutCycles);
      $display("Error counts: %0d mismatches, 1 timeouts", mismatches);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    seed      = 32'h0310_1178;
    rst       = 1'b1;
    InstrD    = '0;
    FlagsE    = '0;
    {Match1EM, Match1EW, Match2EM, Match2EW, Match12DE} = '0;
    memWait   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (NumCycles) begin
      @(negedge clk);
      driveRandom();
    end
    @(negedge clk);
    InstrD  = '0;   // Drain the pipeline
    memWait = 1'b0;
    repeat (4) @(negedge clk);
    $display("Error counts: %0d mismatches, 0 timeouts", mismatches);
    if (mismatches == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/armCtrlPkg.sv
hdl/mainDecoder.sv
hdl/conditional.sv
hdl/hazard.sv
hdl/controller.sv
hdl/armControlUnit.sv
bench/tbControlUnit.sv

/* run.sh */
#!/bin/sh
# Compile and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tbControlUnit -f build.f

status=0
./obj_dir/VtbControlUnit > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit "$status"
